//--- design/bch_pkg.sv
`default_nettype none

package bch_pkg;

	// ==============================
	// vector types
	// ==============================

	// one information byte or one check byte on the stream.
	typedef logic [7:0] byte_t;

	// running remainder of the division.
	// in t=1 mode only the low byte carries the remainder.
	typedef logic [15:0] rem_t;

	// frame mode, 0 selects t=1 and 1 selects t=2.
	typedef logic mode_t;

	// ==============================
	// code constants
	// ==============================

	// generators without their leading term, aligned to bit 0.
	// t=1 is x^8+x^4+x^3+x^2+1.
	localparam rem_t gen_poly_t1 = 16'h001D;
	// t=2 is x^16+x^14+x^13+x^11+x^10+x^9+x^8+x^6+x^5+x+1.
	localparam rem_t gen_poly_t2 = 16'h6F63;

	// remainder widths of the two codes, equal to the generator degree.
	localparam int rem_width_t1 = 8;
	localparam int rem_width_t2 = 16;

	// one division step per message bit, so eight per byte.
	localparam int steps_per_byte = 8;

	// longest information frame the encoder accepts.
	localparam int max_info_bytes = 239;

	// ==============================
	// frame controller states
	// ==============================

	// idle waits for init_vld, load waits for the first byte,
	// data takes bytes and tail issues the second check request in t=2 mode.
	typedef enum logic [1:0] {
		idle,
		load,
		data,
		tail
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- design/bch_stream_if.sv
`default_nettype none

interface bch_stream_if (
	input wire logic sys_clk
);
	import bch_pkg::*;

	// one-cycle strobe, the byte on msg enters the division chain.
	logic  step;
	// information byte being divided, valid with step.
	byte_t msg;
	// code selection of the current frame.
	mode_t mode;
	// one-cycle strobe, the held remainder returns to zero.
	logic  clear;

	// remainder as it passes the bit steps.
	// index 0 is the held remainder, the last index is the result after eight bits.
	rem_t  rem_chain [steps_per_byte + 1];

	// the frame controller feeds the stream.
	modport feeder (output step, output msg, output mode, output clear);

	// each bit step reads its own element and drives the next one.
	modport stage (input sys_clk, input step, input msg, input mode, output rem_chain);

	// the parity stage holds the remainder at index 0 and takes the last index back.
	// it also reads msg to pass the information bytes through.
	modport drain (input step, input msg, input mode, input clear, output rem_chain);

endinterface

`default_nettype wire

//--- design/bch_frame_ctrl.sv
`default_nettype none

module bch_frame_ctrl (
	input  wire logic           sys_clk,
	input  wire logic           rst_n,
	input  wire logic           fs_en,
	input  wire bch_pkg::mode_t frame_mode,
	input  wire logic           init_vld,
	input  wire logic           frame_vld,
	input  wire bch_pkg::byte_t byte_in,
	bch_stream_if.feeder        strm,
	output logic                tail_req
);
	import bch_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	mode_t       mode_q;
	logic        init_pend;
	logic  [7:0] byte_cnt;
	logic        take_init;
	logic        take_byte;
	logic        frame_end;
	logic        tail_more;

	// ==============================
	// input qualification
	// ==============================

	// init_vld counts only on an fs_en cycle.
	// it is ignored in the middle of a frame so the remainder is not lost.
	assign take_init = fs_en & init_vld & ~(state == data & frame_vld);

	// a byte is taken while a frame is open.
	// an init_vld in idle opens the frame on the same strobe.
	assign take_byte = fs_en & frame_vld &
		((state == load) | (state == data) | ((state == idle) & init_vld));

	// the first low frame_vld after data ends the frame and asks for the first check byte.
	assign frame_end = fs_en & ~frame_vld & (state == data);

	// in t=2 mode the next strobe asks for the second check byte.
	assign tail_more = fs_en & (state == tail);

	// ==============================
	// state machine
	// ==============================

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (take_byte) begin
					state_nxt = data;
				end else if (take_init) begin
					state_nxt = load;
				end
			end
			load: begin
				if (take_byte) begin
					state_nxt = data;
				end
			end
			data: begin
				// mode_q still holds the mode of the frame that just ended.
				if (frame_end) begin
					if (mode_q) begin
						state_nxt = tail;
					end else if (take_init) begin
						state_nxt = load;
					end else begin
						state_nxt = idle;
					end
				end
			end
			tail: begin
				// an init_vld seen at the frame end is honoured here.
				if (fs_en) begin
					state_nxt = (take_init | init_pend) ? load : idle;
				end
			end
			default: begin
				state_nxt = idle;
			end
		endcase
	end

	// all stream strobes leave one sys_clk after the fs_en cycle that caused them.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state      <= idle;
			mode_q     <= 1'b0;
			init_pend  <= 1'b0;
			byte_cnt   <= 8'd0;
			strm.step  <= 1'b0;
			strm.clear <= 1'b0;
			tail_req   <= 1'b0;
		end else begin
			state      <= state_nxt;
			strm.step  <= take_byte;
			strm.clear <= take_init;
			tail_req   <= frame_end | tail_more;
			// the mode is fixed for the frame when init_vld arrives.
			if (take_init) begin
				mode_q <= frame_mode;
			end
			// remember an init_vld that arrives while the t=2 tail is still open.
			if (tail_more) begin
				init_pend <= 1'b0;
			end else if (frame_end & mode_q & take_init) begin
				init_pend <= 1'b1;
			end
			// byte_cnt counts the bytes of the current frame and saturates instead of wrapping.
			if (take_byte) begin
				if (state != data) begin
					byte_cnt <= 8'd1;
				end else if (byte_cnt != 8'hFF) begin
					byte_cnt <= byte_cnt + 8'd1;
				end
			end
		end
	end

	// the message byte is registered with step.
	always_ff @(posedge sys_clk) begin
		if (take_byte) begin
			strm.msg <= byte_in;
		end
	end

	assign strm.mode = mode_q;

	// the source offers a byte only inside a frame that init_vld has opened.
	// a byte in the t=2 tail would break the gap between frames and be lost.
	a_byte_in_frame : assert property (@(posedge sys_clk) disable iff (!rst_n)
		(fs_en && frame_vld) |-> take_byte);

	// the source never sends a frame longer than the code allows.
	a_frame_len : assert property (@(posedge sys_clk) disable iff (!rst_n)
		strm.step |-> byte_cnt <= max_info_bytes);

endmodule

`default_nettype wire

//--- design/bch_bit_step.sv
`default_nettype none

module bch_bit_step #(
	parameter int bit_index = 0
) (
	bch_stream_if.stage strm
);
	import bch_pkg::*;

	logic msg_bit;
	logic feedback;
	rem_t rem_in;
	rem_t rem_shift;
	rem_t rem_out;

	// step 0 takes the MSB, so the byte is divided MSB first.
	assign msg_bit = strm.msg[steps_per_byte - 1 - bit_index];
	assign rem_in  = strm.rem_chain[bit_index];

	// ==============================
	// one division step
	// ==============================

	// the message bit meets the top remainder bit of the active code.
	// a one there means the generator is subtracted after the shift.
	always_comb begin
		if (strm.mode == 1'b0) begin
			feedback  = msg_bit ^ rem_in[rem_width_t1 - 1];
			// the upper byte is kept at zero for the 8-bit code.
			rem_shift = {{(rem_width_t2 - rem_width_t1){1'b0}},
				rem_in[rem_width_t1 - 2:0], 1'b0};
			rem_out   = feedback ? (rem_shift ^ gen_poly_t1) : rem_shift;
		end else begin
			feedback  = msg_bit ^ rem_in[rem_width_t2 - 1];
			rem_shift = {rem_in[rem_width_t2 - 2:0], 1'b0};
			rem_out   = feedback ? (rem_shift ^ gen_poly_t2) : rem_shift;
		end
	end

	assign strm.rem_chain[bit_index + 1] = rem_out;

	// in t=1 mode the remainder entering the chain has an empty upper byte.
	// this holds only if the drain cleared it when the frame opened.
	// the later steps get the zeros that the step before them forces.
	if (bit_index == 0) begin : g_chain_in
		a_t1_upper_zero : assert property (@(posedge strm.sys_clk)
			(strm.step && strm.mode == 1'b0) |->
				rem_in[rem_width_t2 - 1:rem_width_t1] == '0);
	end

endmodule

`default_nettype wire

//--- design/bch_parity_out.sv
`default_nettype none

module bch_parity_out (
	input  wire logic       sys_clk,
	input  wire logic       rst_n,
	input  wire logic       fs_en,
	input  wire logic       tail_req,
	bch_stream_if.drain     strm,
	output logic            oe,
	output bch_pkg::byte_t  byte_out
);
	import bch_pkg::*;

	rem_t        rem_q;
	byte_t       chk_q;
	byte_t       chk_byte;
	logic        chk_pend;
	mode_t       frame_two;
	logic  [1:0] frame_chk;

	// ==============================
	// remainder register
	// ==============================

	// the chain starts from zero on a clear cycle.
	// a frame may then begin on the same strobe as its init_vld.
	assign strm.rem_chain[0] = strm.clear ? '0 : rem_q;

	// step has priority, its chain input is already zero if clear is high too.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			rem_q <= '0;
		end else if (strm.step) begin
			rem_q <= strm.rem_chain[steps_per_byte];
		end else if (strm.clear) begin
			rem_q <= '0;
		end
	end

	// ==============================
	// check byte sequencing
	// ==============================

	// the first request of a frame takes the high byte in t=2 mode and the low byte in t=1.
	// the second request takes the byte that was set aside on the first.
	always_comb begin
		if (chk_pend) begin
			chk_byte = chk_q;
		end else if (frame_two) begin
			chk_byte = rem_q[15:8];
		end else begin
			chk_byte = rem_q[7:0];
		end
	end

	// control state of the output stage.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			oe        <= 1'b0;
			chk_pend  <= 1'b0;
			frame_two <= 1'b0;
			frame_chk <= 2'd0;
		end else begin
			// one oe pulse per info byte and per check byte.
			oe <= strm.step | tail_req;
			// the mode is taken from the steps because init_vld of the next frame
			// may change the stream mode before the check bytes are out.
			if (strm.step) begin
				frame_two <= strm.mode;
				frame_chk <= 2'd0;
			end
			if (tail_req) begin
				// a second byte is pending only after the first request of a t=2 frame.
				chk_pend <= ~chk_pend & frame_two;
				if (frame_chk != 2'd3) begin
					frame_chk <= frame_chk + 2'd1;
				end
			end
		end
	end

	// payload of the output stage.
	always_ff @(posedge sys_clk) begin
		if (strm.step) begin
			// info bytes pass through unchanged.
			byte_out <= strm.msg;
		end else if (tail_req) begin
			byte_out <= chk_byte;
		end
		// the low byte is set aside so a clear that arrives meanwhile cannot touch it.
		if (tail_req && !chk_pend) begin
			chk_q <= rem_q[7:0];
		end
	end

	// ==============================
	// checks
	// ==============================

	// a frame never gets more than two check bytes.
	a_chk_count : assert property (@(posedge sys_clk) disable iff (!rst_n)
		tail_req |-> frame_chk < 2'd2);

	// the next frame may not feed the chain before the second check byte is requested.
	a_no_step_in_tail : assert property (@(posedge sys_clk) disable iff (!rst_n)
		chk_pend |-> !strm.step);

	// every strobe from the controller follows an fs_en cycle.
	a_strobe_after_fs_en : assert property (@(posedge sys_clk) disable iff (!rst_n)
		(strm.step || tail_req) |-> $past(fs_en));

endmodule

`default_nettype wire

//--- design/bch_encoder_top.sv
`default_nettype none

module bch_encoder_top (
	input  wire logic       sys_clk,
	input  wire logic       rst_n,
	input  wire logic       fs_en,
	input  wire logic       frame_mode,
	input  wire logic       init_vld,
	input  wire logic       frame_vld,
	input  wire logic [7:0] byte_in,
	output logic            oe,
	output logic      [7:0] byte_out
);
	import bch_pkg::*;

	// request for one check byte, from the controller to the output stage.
	logic tail_req;

	// ==============================
	// stream between the stages
	// ==============================

	bch_stream_if strm (
		.sys_clk (sys_clk)
	);

	// the controller registers the inputs and issues step, clear and tail requests.
	bch_frame_ctrl i_bch_frame_ctrl (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.fs_en      (fs_en),
		.frame_mode (frame_mode),
		.init_vld   (init_vld),
		.frame_vld  (frame_vld),
		.byte_in    (byte_in),
		.strm       (strm.feeder),
		.tail_req   (tail_req)
	);

	// ==============================
	// division chain
	// ==============================

	// eight bit steps fold a whole byte into the remainder in one cycle.
	// step i reads rem_chain[i] and drives rem_chain[i+1].
	for (genvar i = 0; i < steps_per_byte; i++) begin : g_step
		bch_bit_step #(
			.bit_index (i)
		) i_bch_bit_step (
			.strm (strm.stage)
		);
	end

	// ==============================
	// output stage
	// ==============================

	// the output stage holds the remainder and sends info bytes then check bytes.
	bch_parity_out i_bch_parity_out (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.fs_en    (fs_en),
		.tail_req (tail_req),
		.strm     (strm.drain),
		.oe       (oe),
		.byte_out (byte_out)
	);

endmodule

`default_nettype wire

//--- tb/bch_ref_model.svh
`ifndef BCH_REF_MODEL_SVH
`define BCH_REF_MODEL_SVH

// ==============================
// reference model
// ==============================

// full generators, leading term included.
// t=1 is x^8+x^4+x^3+x^2+1.
localparam logic [16:0] ref_gen_t1 = 17'h0011D;
// t=2 is x^16+x^14+x^13+x^11+x^10+x^9+x^8+x^6+x^5+x+1.
localparam logic [16:0] ref_gen_t2 = 17'h16F63;

// remainder of info(x) * x^deg modulo the generator, by plain long division.
// message bits enter MSB first, then deg zero bits complete the division.
function automatic logic [15:0] ref_check(input logic mode, input logic [7:0] info [$]);
	logic [16:0] gen;
	logic [16:0] rem;
	int          deg;
	gen = mode ? ref_gen_t2 : ref_gen_t1;
	deg = mode ? 16 : 8;
	rem = '0;
	for (int i = 0; i < info.size(); i++) begin
		for (int b = 7; b >= 0; b--) begin
			rem = {rem[15:0], info[i][b]};
			// the divisor is subtracted whenever the leading term is set.
			if (rem[deg]) begin
				rem = rem ^ gen;
			end
		end
	end
	// the deg appended zero bits of the systematic form.
	for (int z = 0; z < deg; z++) begin
		rem = {rem[15:0], 1'b0};
		if (rem[deg]) begin
			rem = rem ^ gen;
		end
	end
	return rem[15:0];
endfunction

`endif

//--- tb/tb_bch_encoder.sv
`default_nettype none

module tb_bch_encoder;
	timeunit 1ns;
	timeprecision 1ps;

	// about 700 strobes at two cycles each, with a wide margin.
	localparam int timeout_cycles = 20000;

	logic       sys_clk;
	logic       rst_n;
	logic       fs_en;
	logic       frame_mode;
	logic       init_vld;
	logic       frame_vld;
	logic [7:0] byte_in;
	logic       oe;
	logic [7:0] byte_out;

	int         seed = 32'h51833225;
	int         oe_count = 0;
	int         out_idx = 0;
	int         err_cnt = 0;
	int         pass_tests = 0;
	int         fail_tests = 0;
	logic [7:0] exp_q [$];
	logic [7:0] got_q [$];

	`include "bch_ref_model.svh"

	bch_encoder_top i_bch_encoder_top (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.fs_en      (fs_en),
		.frame_mode (frame_mode),
		.init_vld   (init_vld),
		.frame_vld  (frame_vld),
		.byte_in    (byte_in),
		.oe         (oe),
		.byte_out   (byte_out)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#5 sys_clk = ~sys_clk;
		end
	end

	// ==============================
	// capture and compare
	// ==============================

	// oe and byte_out are registered, so they are steady at the falling edge.
	always @(negedge sys_clk) begin
		if (rst_n && oe) begin
			got_q.push_back(byte_out);
			oe_count++;
		end
	end

	// every captured byte is matched in order against the expected stream.
	always @(posedge sys_clk) begin : compare_out
		logic [7:0] got_byte;
		logic [7:0] want_byte;
		while (got_q.size() != 0) begin
			got_byte = got_q.pop_front();
			if (exp_q.size() == 0) begin
				$display("unexpected output byte %02h at %0t while no byte was due", got_byte, $time);
				err_cnt++;
			end else begin
				want_byte = exp_q.pop_front();
				if (got_byte !== want_byte) begin
					$display("[FAIL] %0t output byte %0d is %02h, expected %02h",
						$time, out_idx, got_byte, want_byte);
					err_cnt++;
				end
				out_idx++;
			end
		end
	end

	// ==============================
	// stimulus
	// ==============================

	// hold the slot values until a random fs_en strobe takes them.
	task automatic drive_strobe(input logic init, input logic fvld, input logic mode,
		input logic [7:0] data);
		int   rnd;
		logic en;
		en = 1'b0;
		while (!en) begin
			@(negedge sys_clk);
			rnd        = $random(seed);
			en         = rnd[0];
			fs_en      = en;
			init_vld   = init;
			frame_vld  = fvld;
			frame_mode = mode;
			byte_in    = data;
		end
	endtask

	function automatic int rand_len(input int max_len);
		int rnd;
		rnd = $random(seed);
		return 1 + ((rnd & 32'h7FFFFFFF) % max_len);
	endfunction

	// init strobe, the info bytes, then one low strobe that closes the frame.
	task automatic send_frame(input logic mode, input int len, input logic zero);
		logic [7:0]  info [$];
		logic [15:0] chk;
		int          rnd;
		for (int i = 0; i < len; i++) begin
			rnd = $random(seed);
			info.push_back(zero ? 8'h00 : rnd[7:0]);
		end
		chk = ref_check(mode, info);
		foreach (info[i]) begin
			exp_q.push_back(info[i]);
		end
		if (mode) begin
			exp_q.push_back(chk[15:8]);
		end
		exp_q.push_back(chk[7:0]);
		drive_strobe(1'b1, 1'b0, mode, 8'h00);
		foreach (info[i]) begin
			drive_strobe(1'b0, 1'b1, mode, info[i]);
		end
		drive_strobe(1'b0, 1'b0, mode, 8'h00);
	endtask

	// idle strobes drain the check bytes, a few more catch any extra byte.
	task automatic finish_test(input string name, input int err_before);
		while (exp_q.size() != 0) begin
			drive_strobe(1'b0, 1'b0, frame_mode, 8'h00);
		end
		repeat (4) drive_strobe(1'b0, 1'b0, frame_mode, 8'h00);
		@(negedge sys_clk);
		fs_en = 1'b0;
		repeat (4) @(posedge sys_clk);
		if (err_cnt == err_before) begin
			pass_tests++;
			$display("test %s: ok", name);
		end else begin
			fail_tests++;
			$display("test %s: %0d errors", name, err_cnt - err_before);
		end
	endtask

	initial begin : main
		int   err_before;
		logic mode;
		fs_en      = 1'b0;
		frame_mode = 1'b0;
		init_vld   = 1'b0;
		frame_vld  = 1'b0;
		byte_in    = 8'h00;
		rst_n      = 1'b0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;

		err_before = err_cnt;
		if (oe !== 1'b0) begin
			$display("[FAIL] %0t oe is not low after reset", $time);
			err_cnt++;
		end
		repeat (40) drive_strobe(1'b0, 1'b0, 1'b0, 8'h00);
		@(posedge sys_clk);
		if (oe_count != 0) begin
			$display("[FAIL] %0t oe pulsed %0d times with no frame", $time, oe_count);
			err_cnt++;
		end
		finish_test("reset_idle", err_before);

		err_before = err_cnt;
		repeat (8) send_frame(1'b0, rand_len(32), 1'b0);
		finish_test("mode0_random", err_before);

		err_before = err_cnt;
		repeat (8) send_frame(1'b1, rand_len(32), 1'b0);
		finish_test("mode1_random", err_before);

		// a zero frame right after a non-zero one shows that init_vld clears the remainder.
		err_before = err_cnt;
		send_frame(1'b0, 12, 1'b0);
		send_frame(1'b0, 12, 1'b1);
		send_frame(1'b1, 16, 1'b0);
		send_frame(1'b1, 16, 1'b1);
		finish_test("all_zero", err_before);

		err_before = err_cnt;
		mode = 1'b0;
		repeat (10) begin
			send_frame(mode, rand_len(16), 1'b0);
			mode = ~mode;
		end
		finish_test("back_to_back", err_before);

		err_before = err_cnt;
		send_frame(1'b1, 239, 1'b0);
		finish_test("max_length", err_before);

		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			pass_tests, fail_tests, err_cnt);
		if (fail_tests == 0 && err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// the run ends here if the encoder stops producing bytes.
	initial begin : watchdog
		int cycle_cnt;
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+tb
design/bch_pkg.sv
design/bch_stream_if.sv
design/bch_frame_ctrl.sv
design/bch_bit_step.sv
design/bch_parity_out.sv
design/bch_encoder_top.sv
tb/tb_bch_encoder.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_bch_encoder \
	-f compile.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
